// ==== csi_rx_pkg.sv ====
// ------------------------------
// shared constants and types for the two-lane CSI-2 byte-clock receiver
// sync byte value assumes LSB-first deserialization
// only RAW10 payload is unpacked, other data types pass as headers only
// ------------------------------

package csi_rx_pkg;

   localparam int NUM_LANE = 2;                  // data lanes
   localparam int MAX_SKEW = 2;                  // lane skew absorbed, byte clocks

   localparam logic [7:0] SYNC_BYTE = 8'hB8;     // HS sync as seen after deser

   // short packet data types
   localparam logic [7:0] DT_FRAME_START = 8'h00;
   localparam logic [7:0] DT_FRAME_END   = 8'h01;
   localparam logic [7:0] DT_LINE_START  = 8'h02;
   localparam logic [7:0] DT_LINE_END    = 8'h03;

   localparam logic [7:0] DT_RAW10 = 8'h2B;      // long packet, raw 10 bit

   localparam int PIX_W            = 10;         // raw10 pixel width
   localparam int RAW10_GROUP      = 5;          // bytes per 4 pixels
   localparam int UNPACK_BUF_BYTES = 10;         // unpacker byte buffer
   localparam int UNPACK_CNT_W     = $clog2(UNPACK_BUF_BYTES + 1);
   localparam int SKEW_CNT_W       = $clog2(MAX_SKEW + 2);  // one spare for overrun

   typedef logic [7:0] bus8_t;

   // lane 0 sits in the low byte
   typedef logic [NUM_LANE-1:0][7:0] lane_data_t;
   typedef logic [NUM_LANE-1:0]      lane_vld_t;

   typedef logic [2*PIX_W-1:0] pix_pair_t;      // pixel 0 in low bits

endpackage: csi_rx_pkg

// ==== csi_rx_align_byte.sv ====
// ------------------------------
// per-lane bit alignment on the HS sync byte
// lane must idle at all zero bits before the sync byte
// offset stays locked until packet_done, search only while wait_for_sync
// ------------------------------
`timescale 1ns/1ns

module csi_rx_align_byte (
   input  logic              byte_clock,
   input  logic              rst_n,
   input  logic              enable,
   input  csi_rx_pkg::bus8_t deser_in,
   input  logic              wait_for_sync,
   input  logic              packet_done,
   output csi_rx_pkg::bus8_t data_out,
   output logic              data_vld
);
   import csi_rx_pkg::*;

   logic [7:0]  prev_q;          // previous deser byte
   logic [15:0] win;             // current byte above previous one
   logic [7:0]  cand [8];        // byte at each bit offset
   logic        hit;
   logic [2:0]  hit_off;
   logic [2:0]  off_q;           // locked offset
   logic        locked;

   assign win = {deser_in, prev_q};

   // offsets 1 to 8 so the sync byte is always complete in this cycle
   always_comb begin
      for (int k = 0; k < 8; k++) begin
         cand[k] = win[k+1 +: 8];
      end
   end

   // lowest matching offset wins
   always_comb begin
      hit     = 1'b0;
      hit_off = '0;
      for (int k = 7; k >= 0; k--) begin
         if (cand[k] == SYNC_BYTE) begin
            hit     = 1'b1;
            hit_off = 3'(k);
         end
      end
   end

//------------------------------
// lock control
//------------------------------
   always_ff @(posedge byte_clock or negedge rst_n) begin
      if (!rst_n) begin
         locked   <= 1'b0;
         off_q    <= '0;
         data_vld <= 1'b0;
      end
      else if (!enable) begin
         locked   <= 1'b0;
         off_q    <= '0;
         data_vld <= 1'b0;
      end
      else begin
         data_vld <= locked && !packet_done;  // first byte follows the sync
         if (packet_done) begin
            locked <= 1'b0;                   // rearm for next packet
         end
         else if (!locked && wait_for_sync && hit) begin
            locked <= 1'b1;
            off_q  <= hit_off;
         end
      end
   end

   // datapath
   always_ff @(posedge byte_clock) begin
      prev_q   <= deser_in;
      data_out <= cand[off_q];
   end

   a_vld_locked: assert property (@(posedge byte_clock) disable iff (!rst_n)
      data_vld |-> locked);

endmodule: csi_rx_align_byte

// ==== csi_rx_align_word.sv ====
// ------------------------------
// lane deskew, up to MAX_SKEW byte clocks between first and last lane
// tap choice is frozen when the last lane turns valid
// all lanes drop together on packet_done
// ------------------------------
`timescale 1ns/1ns

module csi_rx_align_word (
   input  logic                   byte_clock,
   input  logic                   rst_n,
   input  logic                   enable,
   input  logic                   packet_done,
   input  logic                   wait_for_sync,
   input  csi_rx_pkg::lane_data_t word_in,
   input  csi_rx_pkg::lane_vld_t  valid_in,
   output logic                   packet_done_out,
   output csi_rx_pkg::lane_data_t word_out,
   output logic                   valid_out
);
   import csi_rx_pkg::*;

   logic [7:0]            dly_q   [NUM_LANE][MAX_SKEW];   // per lane delay line
   logic [7:0]            taps    [NUM_LANE][MAX_SKEW+1]; // tap 0 is live input
   logic [SKEW_CNT_W-1:0] vcnt_q  [NUM_LANE];             // cycles valid so far
   logic [SKEW_CNT_W-1:0] sel_q   [NUM_LANE];
   logic [SKEW_CNT_W-1:0] cur_sel [NUM_LANE];
   logic                  aligned_q;
   logic                  all_vld;
   logic                  start;

   assign all_vld = &valid_in;
   assign start   = all_vld && !aligned_q && wait_for_sync;

   assign packet_done_out = packet_done;  // byte aligners drop lock with the handler

   always_comb begin
      for (int i = 0; i < NUM_LANE; i++) begin
         taps[i][0] = word_in[i];
         for (int d = 0; d < MAX_SKEW; d++) begin
            taps[i][d+1] = dly_q[i][d];
         end
         // live count on the start cycle, clamped to the delay line
         if (aligned_q)
            cur_sel[i] = sel_q[i];
         else if (vcnt_q[i] > SKEW_CNT_W'(MAX_SKEW))
            cur_sel[i] = SKEW_CNT_W'(MAX_SKEW);
         else
            cur_sel[i] = vcnt_q[i];
      end
   end

//------------------------------
// skew tracking
//------------------------------
   always_ff @(posedge byte_clock or negedge rst_n) begin
      if (!rst_n) begin
         aligned_q <= 1'b0;
         valid_out <= 1'b0;
         vcnt_q    <= '{default: '0};
         sel_q     <= '{default: '0};
      end
      else if (!enable || packet_done) begin
         aligned_q <= 1'b0;
         valid_out <= 1'b0;
         vcnt_q    <= '{default: '0};
         sel_q     <= '{default: '0};
      end
      else begin
         for (int i = 0; i < NUM_LANE; i++) begin
            if (valid_in[i] && !aligned_q && vcnt_q[i] != '1)
               vcnt_q[i] <= vcnt_q[i] + 1'b1;
         end
         if (start) begin
            aligned_q <= 1'b1;
            sel_q     <= vcnt_q;   // early lanes read older taps
         end
         valid_out <= aligned_q ? all_vld : start;
      end
   end

   // delay lines and output word
   always_ff @(posedge byte_clock) begin
      for (int i = 0; i < NUM_LANE; i++) begin
         dly_q[i][0] <= word_in[i];
         for (int d = 1; d < MAX_SKEW; d++) begin
            dly_q[i][d] <= dly_q[i][d-1];
         end
         word_out[i] <= taps[i][cur_sel[i]];
      end
   end

   for (genvar g = 0; g < NUM_LANE; g++) begin: g_skew_chk
      a_max_skew: assert property (@(posedge byte_clock) disable iff (!rst_n)
         (!aligned_q && valid_in[g]) |-> (vcnt_q[g] <= SKEW_CNT_W'(MAX_SKEW)));
   end: g_skew_chk

endmodule: csi_rx_align_word

// ==== csi_rx_packet_handler.sv ====
// ------------------------------
// CSI-2 packet parser for two-lane words
// ECC and CRC bytes are skipped, not checked
// only DT_RAW10 long packets carry payload, virtual channel ignored
// ------------------------------
`timescale 1ns/1ns

module csi_rx_packet_handler (
   input  logic                   byte_clock,
   input  logic                   rst_n,
   input  logic                   enable,
   input  csi_rx_pkg::lane_data_t data,
   input  logic                   data_valid,
   output logic                   sync_wait,
   output logic                   packet_done,
   output csi_rx_pkg::lane_data_t payload_out,
   output logic                   payload_valid,
   output logic                   in_frame,
   output logic                   in_line
);
   import csi_rx_pkg::*;

   typedef enum logic [1:0] {ST_HEADER, ST_PAYLOAD, ST_CRC, ST_DONE} state_t;

   state_t      state_q;
   logic        hdr_second_q;    // second header word pending
   logic [7:0]  data_id_q;
   logic [7:0]  wc_lo_q;
   logic [15:0] word_cnt_q;      // payload words left
   logic [7:0]  dt;
   logic [15:0] wc_words;

   assign dt       = {2'b00, data_id_q[5:0]};        // drop VC bits
   assign wc_words = {1'b0, data[0], wc_lo_q[7:1]};  // byte count / 2 lanes

   assign sync_wait   = (state_q == ST_HEADER) && !hdr_second_q;
   assign packet_done = (state_q == ST_DONE);

//------------------------------
// packet FSM
//------------------------------
   always_ff @(posedge byte_clock or negedge rst_n) begin
      if (!rst_n) begin
         state_q       <= ST_HEADER;
         hdr_second_q  <= 1'b0;
         data_id_q     <= '0;
         wc_lo_q       <= '0;
         word_cnt_q    <= '0;
         payload_valid <= 1'b0;
         in_frame      <= 1'b0;
         in_line       <= 1'b0;
      end
      else if (!enable) begin
         state_q       <= ST_HEADER;
         hdr_second_q  <= 1'b0;
         data_id_q     <= '0;
         wc_lo_q       <= '0;
         word_cnt_q    <= '0;
         payload_valid <= 1'b0;
         in_frame      <= 1'b0;
         in_line       <= 1'b0;
      end
      else begin
         payload_valid <= 1'b0;
         case (state_q)
            ST_HEADER: if (data_valid) begin
               if (!hdr_second_q) begin
                  data_id_q    <= data[0];   // DI on lane 0
                  wc_lo_q      <= data[1];
                  hdr_second_q <= 1'b1;
               end
               else begin
                  hdr_second_q <= 1'b0;      // lane 1 ECC ignored
                  state_q      <= ST_DONE;   // short and unknown types end here
                  case (dt)
                     DT_FRAME_START: in_frame <= 1'b1;
                     DT_FRAME_END: begin
                        in_frame <= 1'b0;
                        in_line  <= 1'b0;
                     end
                     DT_LINE_START: in_line <= 1'b1;
                     DT_LINE_END:   in_line <= 1'b0;
                     DT_RAW10: begin
                        word_cnt_q <= wc_words;
                        state_q    <= (wc_words == '0) ? ST_CRC : ST_PAYLOAD;
                     end
                     default: state_q <= ST_DONE;
                  endcase
               end
            end
            ST_PAYLOAD: if (data_valid) begin
               payload_valid <= 1'b1;
               word_cnt_q    <= word_cnt_q - 1'b1;
               if (word_cnt_q == 16'd1) state_q <= ST_CRC;
            end
            ST_CRC: if (data_valid) state_q <= ST_DONE;   // 2 CRC bytes, one word
            default: state_q <= ST_HEADER;                // done pulse, back to idle
         endcase
      end
   end

   always_ff @(posedge byte_clock) begin
      if (state_q == ST_PAYLOAD && data_valid) payload_out <= data;
   end

   a_payload_in_line: assert property (@(posedge byte_clock) disable iff (!rst_n)
      payload_valid |-> in_line);

endmodule: csi_rx_packet_handler

// ==== csi_rx_10bit_unpack.sv ====
// ------------------------------
// RAW10 unpack, 5 bytes give 4 pixels, one pixel pair per cycle
// payload length per line should be a multiple of 5 bytes
// leftover bytes are cleared only by reset or enable low
// ------------------------------
`timescale 1ns/1ns

module csi_rx_10bit_unpack (
   input  logic                   byte_clock,
   input  logic                   rst_n,
   input  logic                   enable,
   input  csi_rx_pkg::lane_data_t data_in,
   input  logic                   din_valid,
   output csi_rx_pkg::pix_pair_t  data_out,
   output logic                   dout_valid
);
   import csi_rx_pkg::*;

   logic [7:0]              buf_q [UNPACK_BUF_BYTES];  // b0 at index 0
   logic [7:0]              buf_d [UNPACK_BUF_BYTES];
   logic [UNPACK_CNT_W-1:0] cnt_q;
   logic [UNPACK_CNT_W-1:0] cnt_d;
   logic                    half_q;   // second pair of the group
   logic                    pop;

   assign dout_valid = (cnt_q >= UNPACK_CNT_W'(RAW10_GROUP));
   assign pop        = dout_valid && half_q;

   // pixel k = {b_k, b4 bits 2k+1:2k}
   always_comb begin
      if (half_q)
         data_out = {buf_q[3], buf_q[4][7:6], buf_q[2], buf_q[4][5:4]};
      else
         data_out = {buf_q[1], buf_q[4][3:2], buf_q[0], buf_q[4][1:0]};
   end

   // drop a finished group, then append the new word
   always_comb begin
      buf_d = buf_q;
      cnt_d = cnt_q;
      if (pop) begin
         for (int i = 0; i < UNPACK_BUF_BYTES - RAW10_GROUP; i++) begin
            buf_d[i] = buf_q[i + RAW10_GROUP];
         end
         cnt_d = cnt_q - UNPACK_CNT_W'(RAW10_GROUP);
      end
      if (din_valid) begin
         for (int b = 0; b < NUM_LANE; b++) begin
            if (int'(cnt_d) + b < UNPACK_BUF_BYTES) buf_d[int'(cnt_d) + b] = data_in[b];
         end
         cnt_d = cnt_d + UNPACK_CNT_W'(NUM_LANE);
      end
   end

   always_ff @(posedge byte_clock or negedge rst_n) begin
      if (!rst_n) begin
         cnt_q  <= '0;
         half_q <= 1'b0;
      end
      else if (!enable) begin
         cnt_q  <= '0;
         half_q <= 1'b0;
      end
      else begin
         cnt_q <= cnt_d;
         if (dout_valid) half_q <= !half_q;
      end
   end

   always_ff @(posedge byte_clock) begin
      buf_q <= buf_d;
   end

   a_buf_room: assert property (@(posedge byte_clock) disable iff (!rst_n)
      cnt_q < UNPACK_CNT_W'(UNPACK_BUF_BYTES));

endmodule: csi_rx_10bit_unpack

// ==== csi_rx_top.sv ====
// ------------------------------
// CSI-2 receiver core on the byte clock, deser bytes in, RAW10 pairs out
// PHY, IO delays and clock detection sit outside this block
// ------------------------------
`timescale 1ns/1ns

module csi_rx_top (
   input  logic                   byte_clock,
   input  logic                   rst_n,
   input  logic                   cam_en,
   input  csi_rx_pkg::lane_data_t deser_in,
   output csi_rx_pkg::pix_pair_t  csi_unpack_raw_dat,
   output logic                   csi_unpack_raw_dat_vld,
   output logic                   csi_in_line,
   output logic                   csi_in_frame
);
   import csi_rx_pkg::*;

   logic       wait_for_sync;
   logic       byte_packet_done;
   logic       packet_done;
   lane_data_t byte_align_data;
   lane_vld_t  byte_valid;
   lane_data_t word_data;
   logic       word_valid;
   lane_data_t unpack_dat;
   logic       unpack_dat_vld;

//------------------------------
// byte and word alignment
//------------------------------
   csi_rx_align_byte u_align_byte [NUM_LANE-1:0] (
      .byte_clock      (byte_clock),        //i
      .rst_n           (rst_n),             //i
      .enable          (cam_en),            //i
      .deser_in        (deser_in),          //i one byte per lane
      .wait_for_sync   (wait_for_sync),     //i
      .packet_done     (byte_packet_done),  //i
      .data_out        (byte_align_data),   //o
      .data_vld        (byte_valid)         //o
   );

   csi_rx_align_word u_align_word (
      .byte_clock      (byte_clock),        //i
      .rst_n           (rst_n),             //i
      .enable          (cam_en),            //i
      .packet_done     (packet_done),       //i
      .wait_for_sync   (wait_for_sync),     //i
      .word_in         (byte_align_data),   //i
      .valid_in        (byte_valid),        //i
      .packet_done_out (byte_packet_done),  //o
      .word_out        (word_data),         //o
      .valid_out       (word_valid)         //o
   );

//------------------------------
// packets and pixels
//------------------------------
   csi_rx_packet_handler u_depacket (
      .byte_clock      (byte_clock),        //i
      .rst_n           (rst_n),             //i
      .enable          (cam_en),            //i
      .data            (word_data),         //i
      .data_valid      (word_valid),        //i
      .sync_wait       (wait_for_sync),     //o
      .packet_done     (packet_done),       //o
      .payload_out     (unpack_dat),        //o
      .payload_valid   (unpack_dat_vld),    //o
      .in_frame        (csi_in_frame),      //o
      .in_line         (csi_in_line)        //o
   );

   csi_rx_10bit_unpack u_10bit_unpack (
      .byte_clock      (byte_clock),             //i
      .rst_n           (rst_n),                  //i
      .enable          (cam_en),                 //i
      .data_in         (unpack_dat),             //i
      .din_valid       (unpack_dat_vld),         //i
      .data_out        (csi_unpack_raw_dat),     //o
      .dout_valid      (csi_unpack_raw_dat_vld)  //o
   );

endmodule: csi_rx_top

// ==== tb_csi_rx.sv ====
// ------------------------------
// testbench for csi_rx_top, two lanes, RAW10 payload only
// bit offsets and lane skew change per frame, LCG with a fixed seed
// sync of the late lane completes 0 to 2 cycles after the early lane
// last frame is sent with cam_en low and must give no output
// ------------------------------
`timescale 1ns/1ns

module tb_csi_rx;
   import csi_rx_pkg::*;

   localparam int NUM_FRAMES = 6;

   logic       byte_clock = 1'b0;
   logic       rst_n;
   logic       cam_en;
   lane_data_t deser_in;
   pix_pair_t  csi_unpack_raw_dat;
   logic       csi_unpack_raw_dat_vld;
   logic       csi_in_line;
   logic       csi_in_frame;

   logic [31:0] lcg_state = 32'h22e5;
   logic [7:0]  ulane0 [$];      // frame bytes before the bit shift, lane 0
   logic [7:0]  ulane1 [$];
   logic [7:0]  lane0_q [$];     // deser stream, one byte per cycle
   logic [7:0]  lane1_q [$];
   logic        en_q [$];        // cam_en per cycle
   logic        fend_q [$];      // last cycle of an enabled frame
   pix_pair_t   exp_q [$];       // model pixel pairs
   int          line_pix_q [$];  // model pixels per line
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   int          cycle_limit = 0;
   int          line_pix = 0;
   logic        in_line_d = 1'b0;
   int          skew_base;

   always #10 byte_clock = ~byte_clock;   // 20 ns

   csi_rx_top DUT (
      .byte_clock             (byte_clock),
      .rst_n                  (rst_n),
      .cam_en                 (cam_en),
      .deser_in               (deser_in),
      .csi_unpack_raw_dat     (csi_unpack_raw_dat),
      .csi_unpack_raw_dat_vld (csi_unpack_raw_dat_vld),
      .csi_in_line            (csi_in_line),
      .csi_in_frame           (csi_in_frame)
   );

   function automatic int unsigned rand_next(input int unsigned range);
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return (lcg_state >> 8) % range;   // low bits of an LCG are weak
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   // output byte idx of one lane, stream delayed by dly bits, LSB first
   function automatic logic [7:0] shifted_byte(input int lane, input int idx, input int dly);
      logic [7:0] b;
      logic [7:0] src;
      int         j;
      b = '0;
      for (int k = 0; k < 8; k++) begin
         j = 8 * idx + k - dly;
         if (j >= 0 && j < 8 * ulane0.size()) begin
            src  = (lane == 0) ? ulane0[j / 8] : ulane1[j / 8];
            b[k] = src[j % 8];
         end
      end
      return b;
   endfunction

//------------------------------
// packet builder and RAW10 model
//------------------------------
   task automatic add_packet(input logic [7:0] dt, input int n_pay, input bit model_on);
      logic [15:0] wc;
      logic [7:0]  grp [5];
      logic [9:0]  pix [4];
      int          gap;
      wc = (dt == DT_RAW10) ? 16'(n_pay) : 16'(rand_next(65536));
      ulane0.push_back(SYNC_BYTE);
      ulane1.push_back(SYNC_BYTE);
      ulane0.push_back(dt);                    // DI, virtual channel 0
      ulane1.push_back(wc[7:0]);
      ulane0.push_back(wc[15:8]);
      ulane1.push_back(8'(rand_next(256)));    // ECC byte, random
      for (int g = 0; g < n_pay / 5; g++) begin
         for (int k = 0; k < 5; k++) begin
            grp[k] = 8'(rand_next(256));
            if ((5 * g + k) % 2 == 0)
               ulane0.push_back(grp[k]);         // even bytes on lane 0
            else
               ulane1.push_back(grp[k]);
         end
         // pixel k: b_k on top, two lsbs from b4
         for (int k = 0; k < 4; k++) begin
            pix[k] = {grp[k], grp[4][2 * k +: 2]};
         end
         if (model_on) begin
            exp_q.push_back({pix[1], pix[0]});
            exp_q.push_back({pix[3], pix[2]});
         end
      end
      if (dt == DT_RAW10) begin
         ulane0.push_back(8'(rand_next(256)));   // crc, random
         ulane1.push_back(8'(rand_next(256)));
      end
      gap = 6 + int'(rand_next(6));             // idle zeros, covers skew 2
      repeat (gap) begin
         ulane0.push_back(8'h00);
         ulane1.push_back(8'h00);
      end
   endtask

   task automatic build_frame(input bit enabled, input int skew);
      int n_lines;
      int n_pay;
      int late;
      int len;
      int off [2];
      int dly [2];
      ulane0.delete();
      ulane1.delete();
      repeat (4) begin
         ulane0.push_back(8'h00);
         ulane1.push_back(8'h00);
      end
      add_packet(DT_FRAME_START, 0, enabled);
      n_lines = 2 + int'(rand_next(3));
      for (int l = 0; l < n_lines; l++) begin
         case (rand_next(3))
            0:       n_pay = 10;
            1:       n_pay = 20;
            default: n_pay = 40;
         endcase
         add_packet(DT_LINE_START, 0, enabled);
         add_packet(DT_RAW10, n_pay, enabled);
         add_packet(DT_LINE_END, 0, enabled);
         if (enabled) line_pix_q.push_back(n_pay * 4 / 5);
      end
      add_packet(DT_FRAME_END, 0, enabled);
      // sync completes 1 cycle in on the early lane, 1 + skew on the late one
      late = int'(rand_next(2));
      for (int ln = 0; ln < 2; ln++) begin
         off[ln] = int'(rand_next(8));
         dly[ln] = 8 * (((ln == late) ? 1 + skew : 1) - ((off[ln] > 0) ? 1 : 0)) + off[ln];
      end
      len = ulane0.size() + 3;                  // room for the largest delay
      for (int i = 0; i < len; i++) begin
         lane0_q.push_back(shifted_byte(0, i, dly[0]));
         lane1_q.push_back(shifted_byte(1, i, dly[1]));
         en_q.push_back(enabled);
         fend_q.push_back(enabled && (i == len - 1));
      end
   endtask

//------------------------------
// output monitor
//------------------------------
   always @(negedge byte_clock) begin
      if (!rst_n || !cam_en) begin             // held in reset state
         check_value("csi_unpack_raw_dat_vld", 32'(csi_unpack_raw_dat_vld), 32'd0);
         check_value("csi_in_line", 32'(csi_in_line), 32'd0);
         check_value("csi_in_frame", 32'(csi_in_frame), 32'd0);
      end
      if (csi_unpack_raw_dat_vld) begin
         check_value("csi_in_line", 32'(csi_in_line), 32'd1);
         check_value("csi_in_frame", 32'(csi_in_frame), 32'd1);
         if (exp_q.size() == 0) begin
            errors++;
            $display("unexpected pixel pair 0x%05h while the model queue is empty",
                     csi_unpack_raw_dat);
         end
         else begin
            check_value("csi_unpack_raw_dat", 32'(csi_unpack_raw_dat), 32'(exp_q.pop_front()));
         end
         line_pix += 2;
      end
      if (in_line_d && !csi_in_line) begin     // end of line
         if (line_pix_q.size() == 0) begin
            errors++;
            $display("line ended with no line expected by the model");
         end
         else begin
            check_value("csi_in_line pixel count", 32'(line_pix), 32'(line_pix_q.pop_front()));
         end
         line_pix = 0;
      end
      in_line_d = csi_in_line;
   end

   // watchdog
   always @(posedge byte_clock) begin
      cycles <= cycles + 1;
      if (cycle_limit != 0 && cycles >= cycle_limit) begin
         $display("timeout after %0d cycles, stimulus never finished", cycles);
         $display("Test failed");
         $finish;
      end
   end

//------------------------------
// main sequence
//------------------------------
   initial begin
      rst_n    = 1'b0;
      cam_en   = 1'b0;
      deser_in = '0;
      // skew walks 0..2 from a random start so every value is hit
      skew_base = int'(rand_next(3));
      for (int f = 0; f < NUM_FRAMES; f++) begin
         build_frame(1'b1, (skew_base + f) % 3);
      end
      build_frame(1'b0, 2);                     // sent with cam_en low
      cycle_limit = 2 * NUM_LANE * lane0_q.size() + 200;

      repeat (8) @(posedge byte_clock);
      rst_n <= 1'b1;
      repeat (8) @(posedge byte_clock);         // idle, cam_en still low
      for (int i = 0; i < lane0_q.size(); i++) begin
         @(posedge byte_clock);
         deser_in <= {lane1_q[i], lane0_q[i]};
         cam_en   <= en_q[i];
         if (fend_q[i]) begin
            @(negedge byte_clock);
            check_value("csi_in_frame", 32'(csi_in_frame), 32'd0);  // frame end seen
         end
      end
      @(posedge byte_clock);
      cam_en   <= 1'b0;
      deser_in <= '0;
      repeat (4) @(posedge byte_clock);

      if (exp_q.size() != 0) begin
         errors++;
         $display("%0d expected pixel pairs never came out", exp_q.size());
      end
      if (line_pix_q.size() != 0) begin
         errors++;
         $display("%0d expected lines never ended", line_pix_q.size());
      end
      $display("summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule: tb_csi_rx

// ==== project.f ====
csi_rx_pkg.sv
csi_rx_align_byte.sv
csi_rx_align_word.sv
csi_rx_packet_handler.sv
csi_rx_10bit_unpack.sv
csi_rx_top.sv
tb_csi_rx.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the CSI-2 receiver testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
   --top-module tb_csi_rx -o tb_csi_rx > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/tb_csi_rx > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Test passed" sim.log; then
   exit 0
fi
exit 1
